// File: design/paint_geom_pkg.sv
package paint_geom_pkg;

  // Square canvas with one byte per pixel
  localparam int CANVAS_SIZE = 64;
  localparam int COORD_W     = $clog2(CANVAS_SIZE);
  localparam int PIXEL_W     = 8;

  // One axis of the canvas. Arithmetic on it wraps at the canvas edge
  typedef logic [COORD_W-1:0] coord_t;

  // High nibble is the hue, low nibble the shade
  typedef logic [PIXEL_W-1:0] pixel_t;

  // The palette strip sits on the last row
  localparam coord_t PALETTE_ROW = coord_t'(CANVAS_SIZE - 1);

  localparam pixel_t CURSOR_PIXEL = 8'hFF;

  // One write towards the external frame buffer
  typedef struct packed {
    logic   valid;
    coord_t x;
    coord_t y;
    pixel_t data;
  } pix_wr_t;

endpackage

// File: design/paint_ctrl_pkg.sv
package paint_ctrl_pkg;

  // Key levels, already clean
  typedef struct packed {
    logic pick_palette;
    logic paint_now;
    logic select_colour;
  } keys_t;

  typedef enum logic [3:0] {
    ST_IDLE          = 4'd0,
    ST_LATCH         = 4'd1,
    ST_CHECK_PALETTE = 4'd2,
    ST_CHECK_PAINT   = 4'd3,
    ST_DRAW_PALETTE  = 4'd4,
    ST_CHECK_SELECT  = 4'd5,
    ST_CHANGE_COLOUR = 4'd6,
    ST_DRAW_CURSOR   = 4'd7,
    ST_PAINT         = 4'd8
  } paint_state_e;

  localparam int CURSOR_PIXELS    = 4;
  localparam int PALETTE_SWATCHES = 16;

  typedef logic [$clog2(CURSOR_PIXELS)-1:0]    cursor_idx_t;
  typedef logic [$clog2(PALETTE_SWATCHES)-1:0] swatch_t;

endpackage

// File: design/cursor_drawer.sv
`timescale 1ns/1ps

module cursor_drawer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  paint_geom_pkg::coord_t  pos_x,
  input  paint_geom_pkg::coord_t  pos_y,
  output paint_geom_pkg::pix_wr_t wr,
  output logic                    done
);

  paint_ctrl_pkg::cursor_idx_t idx;
  logic                        active;
  logic                        last;
  paint_geom_pkg::coord_t      base_x;
  paint_geom_pkg::coord_t      base_y;

  assign last = (idx == paint_ctrl_pkg::cursor_idx_t'(
                  paint_ctrl_pkg::CURSOR_PIXELS - 1));

  // Walk the box once per start pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      idx    <= '0;
    end else if (start) begin
      active <= 1'b1;
      idx    <= '0;
    end else if (active) begin
      active <= !last;
      idx    <= idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      base_x <= pos_x;
      base_y <= pos_y;
    end
  end

  // Bit 0 of the index steps in x, bit 1 steps in y
  always_comb begin
    wr.valid = active;
    wr.x     = base_x + paint_geom_pkg::coord_t'(idx[0]);
    wr.y     = base_y + paint_geom_pkg::coord_t'(idx[1]);
    wr.data  = paint_geom_pkg::CURSOR_PIXEL;
  end

  assign done = active && last;

endmodule

// File: design/palette_drawer.sv
`timescale 1ns/1ps

module palette_drawer (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    start,
  input  logic [3:0]              shade,
  output paint_geom_pkg::pix_wr_t wr,
  output logic                    done
);

  paint_ctrl_pkg::swatch_t k;
  logic                    active;
  logic                    last;
  logic [3:0]              shade_q;

  assign last = (k == paint_ctrl_pkg::swatch_t'(
                  paint_ctrl_pkg::PALETTE_SWATCHES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
      k      <= '0;
    end else if (start) begin
      active <= 1'b1;
      k      <= '0;
    end else if (active) begin
      active <= !last;
      k      <= k + 1'b1;
    end
  end

  // Every swatch of one strip shares the shade seen at start
  always_ff @(posedge clk) begin
    if (start) begin
      shade_q <= shade;
    end
  end

  // Swatch k goes to column k, with k as its hue
  always_comb begin
    wr.valid = active;
    wr.x     = paint_geom_pkg::coord_t'(k);
    wr.y     = paint_geom_pkg::PALETTE_ROW;
    wr.data  = {k, shade_q};
  end

  assign done = active && last;

endmodule

// File: design/paint_controller.sv
`timescale 1ns/1ps

module paint_controller (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    init,
  input  paint_geom_pkg::coord_t  in_x,
  input  paint_geom_pkg::coord_t  in_y,
  input  paint_ctrl_pkg::keys_t   keys,
  input  paint_geom_pkg::pix_wr_t cursor_wr,
  input  paint_geom_pkg::pix_wr_t palette_wr,
  input  logic                    cursor_done,
  input  logic                    palette_done,
  output logic                    cursor_start,
  output logic                    palette_start,
  output paint_geom_pkg::coord_t  pos_x,
  output paint_geom_pkg::coord_t  pos_y,
  output logic [3:0]              shade,
  output paint_geom_pkg::pix_wr_t pix_wr,
  output logic                    sample_strobe
);

  paint_ctrl_pkg::paint_state_e state;
  paint_ctrl_pkg::paint_state_e state_d;
  paint_geom_pkg::pixel_t       colour;
  paint_geom_pkg::pix_wr_t      merged;

  always_comb begin
    state_d = state;
    case (state)
      paint_ctrl_pkg::ST_IDLE: begin
        if (init) state_d = paint_ctrl_pkg::ST_LATCH;
      end
      paint_ctrl_pkg::ST_LATCH: begin
        state_d = paint_ctrl_pkg::ST_CHECK_PALETTE;
      end
      paint_ctrl_pkg::ST_CHECK_PALETTE: begin
        state_d = keys.pick_palette ? paint_ctrl_pkg::ST_DRAW_PALETTE
                                    : paint_ctrl_pkg::ST_CHECK_PAINT;
      end
      paint_ctrl_pkg::ST_CHECK_PAINT: begin
        state_d = keys.paint_now ? paint_ctrl_pkg::ST_PAINT
                                 : paint_ctrl_pkg::ST_DRAW_CURSOR;
      end
      paint_ctrl_pkg::ST_PAINT: begin
        state_d = paint_ctrl_pkg::ST_LATCH;
      end
      paint_ctrl_pkg::ST_DRAW_CURSOR: begin
        if (cursor_done) state_d = paint_ctrl_pkg::ST_LATCH;
      end
      paint_ctrl_pkg::ST_DRAW_PALETTE: begin
        if (palette_done) state_d = paint_ctrl_pkg::ST_CHECK_SELECT;
      end
      // Keep redrawing the strip until a swatch is taken
      paint_ctrl_pkg::ST_CHECK_SELECT: begin
        state_d = keys.select_colour ? paint_ctrl_pkg::ST_CHANGE_COLOUR
                                     : paint_ctrl_pkg::ST_DRAW_PALETTE;
      end
      paint_ctrl_pkg::ST_CHANGE_COLOUR: begin
        state_d = paint_ctrl_pkg::ST_LATCH;
      end
      default: begin
        state_d = paint_ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= paint_ctrl_pkg::ST_IDLE;
      colour        <= '0;
      cursor_start  <= 1'b0;
      palette_start <= 1'b0;
    end else begin
      state <= state_d;
      if (state == paint_ctrl_pkg::ST_CHANGE_COLOUR) begin
        colour <= {pos_x[3:0], pos_y[3:0]};
      end
      // A start pulse marks the first cycle of each drawing state
      cursor_start  <= (state_d == paint_ctrl_pkg::ST_DRAW_CURSOR) &&
                       (state != paint_ctrl_pkg::ST_DRAW_CURSOR);
      palette_start <= (state_d == paint_ctrl_pkg::ST_DRAW_PALETTE) &&
                       (state != paint_ctrl_pkg::ST_DRAW_PALETTE);
    end
  end

  always_ff @(posedge clk) begin
    if (state == paint_ctrl_pkg::ST_LATCH) begin
      pos_x <= in_x;
      pos_y <= in_y;
    end
  end

  assign sample_strobe = (state == paint_ctrl_pkg::ST_LATCH);
  assign shade         = pos_y[3:0];

  // The state picks the one source allowed onto the output
  always_comb begin
    case (state)
      paint_ctrl_pkg::ST_PAINT: begin
        merged.valid = 1'b1;
        merged.x     = pos_x;
        merged.y     = pos_y;
        merged.data  = colour;
      end
      paint_ctrl_pkg::ST_DRAW_CURSOR:  merged = cursor_wr;
      paint_ctrl_pkg::ST_DRAW_PALETTE: merged = palette_wr;
      default:                         merged = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pix_wr.valid <= 1'b0;
    end else begin
      pix_wr <= merged;
    end
  end

endmodule

// File: design/paint_top.sv
`timescale 1ns/1ps

module paint_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    init,
  input  paint_geom_pkg::coord_t  in_x,
  input  paint_geom_pkg::coord_t  in_y,
  input  paint_ctrl_pkg::keys_t   keys,
  output paint_geom_pkg::pix_wr_t pix_wr,
  output logic                    sample_strobe
);

  paint_geom_pkg::pix_wr_t cursor_wr;
  paint_geom_pkg::pix_wr_t palette_wr;
  logic                    cursor_done;
  logic                    palette_done;
  logic                    cursor_start;
  logic                    palette_start;
  paint_geom_pkg::coord_t  pos_x;
  paint_geom_pkg::coord_t  pos_y;
  logic [3:0]              shade;

  paint_controller i_controller (
    .clk           (clk),
    .rst           (rst),
    .init          (init),
    .in_x          (in_x),
    .in_y          (in_y),
    .keys          (keys),
    .cursor_wr     (cursor_wr),
    .palette_wr    (palette_wr),
    .cursor_done   (cursor_done),
    .palette_done  (palette_done),
    .cursor_start  (cursor_start),
    .palette_start (palette_start),
    .pos_x         (pos_x),
    .pos_y         (pos_y),
    .shade         (shade),
    .pix_wr        (pix_wr),
    .sample_strobe (sample_strobe)
  );

  cursor_drawer i_cursor_drawer (
    .clk   (clk),
    .rst   (rst),
    .start (cursor_start),
    .pos_x (pos_x),
    .pos_y (pos_y),
    .wr    (cursor_wr),
    .done  (cursor_done)
  );

  palette_drawer i_palette_drawer (
    .clk   (clk),
    .rst   (rst),
    .start (palette_start),
    .shade (shade),
    .wr    (palette_wr),
    .done  (palette_done)
  );

endmodule

// File: test/paint_assertions.sv
`timescale 1ns/1ps

module paint_assertions (
  input logic                         clk,
  input logic                         rst,
  input paint_ctrl_pkg::paint_state_e state,
  input paint_geom_pkg::pix_wr_t      cursor_wr,
  input paint_geom_pkg::pix_wr_t      palette_wr,
  input paint_geom_pkg::pix_wr_t      pix_wr,
  input logic                         cursor_start,
  input logic                         palette_start
);

  int fail_count = 0;

  // The output register is cleared on every reset edge
  assert property (@(posedge clk) rst |=> !pix_wr.valid)
    else begin
      fail_count++;
      $error("pixel write valid while reset is held");
    end

  // Paint, cursor and palette never drive the merge in the same cycle
  assert property (@(posedge clk) disable iff (rst)
    $onehot0({cursor_wr.valid, palette_wr.valid, state == paint_ctrl_pkg::ST_PAINT}))
    else begin
      fail_count++;
      $error("more than one pixel source valid");
    end

  assert property (@(posedge clk) disable iff (rst) cursor_start |-> !cursor_wr.valid)
    else begin
      fail_count++;
      $error("cursor start while the cursor drawer is active");
    end

  assert property (@(posedge clk) disable iff (rst) palette_start |-> !palette_wr.valid)
    else begin
      fail_count++;
      $error("palette start while the palette drawer is active");
    end

endmodule

bind paint_controller paint_assertions i_paint_assertions (
  .clk           (clk),
  .rst           (rst),
  .state         (state),
  .cursor_wr     (cursor_wr),
  .palette_wr    (palette_wr),
  .pix_wr        (pix_wr),
  .cursor_start  (cursor_start),
  .palette_start (palette_start)
);

// File: test/paint_tb.sv
`timescale 1ns/1ps

module paint_tb;

  typedef struct packed {
    logic                   rand_pos;
    paint_geom_pkg::coord_t x;
    paint_geom_pkg::coord_t y;
    paint_ctrl_pkg::keys_t  keys;
  } stim_t;

  localparam int TIMEOUT_CYCLES = 100;

  logic                    clk;
  logic                    rst;
  logic                    init;
  paint_geom_pkg::coord_t  in_x;
  paint_geom_pkg::coord_t  in_y;
  paint_ctrl_pkg::keys_t   keys;
  paint_geom_pkg::pix_wr_t pix_wr;
  logic                    sample_strobe;

  stim_t                   rows[$];
  string                   row_names[$];
  paint_geom_pkg::pix_wr_t exp_q[$];
  string                   exp_names[$];
  paint_geom_pkg::pixel_t  model_colour;
  logic                    checking;
  logic                    timed_out;
  int                      mismatches;
  int                      unexpected;
  int                      timeouts;

  paint_top i_paint_top (
    .clk           (clk),
    .rst           (rst),
    .init          (init),
    .in_x          (in_x),
    .in_y          (in_y),
    .keys          (keys),
    .pix_wr        (pix_wr),
    .sample_strobe (sample_strobe)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Key bits are pick_palette, paint_now, select_colour
  task automatic add_row(input string name, input logic rand_pos, input int x, input int y,
                         input logic [2:0] key_bits);
    rows.push_back(stim_t'({rand_pos, paint_geom_pkg::coord_t'(x),
                            paint_geom_pkg::coord_t'(y), key_bits}));
    row_names.push_back(name);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      mismatches++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // Reference model of the writes one sequence should produce
  task automatic predict(input string name, input stim_t s);
    paint_geom_pkg::pix_wr_t w;
    w.valid = 1'b1;
    if (s.keys.pick_palette) begin
      w.y = paint_geom_pkg::PALETTE_ROW;
      for (int k = 0; k < paint_ctrl_pkg::PALETTE_SWATCHES; k++) begin
        w.x    = paint_geom_pkg::coord_t'(k);
        w.data = paint_geom_pkg::pixel_t'(k * 16 + s.y[3:0]);
        exp_q.push_back(w);
        exp_names.push_back(name);
      end
      if (s.keys.select_colour) begin
        model_colour = paint_geom_pkg::pixel_t'((s.x % 16) * 16 + s.y % 16);
      end
    end else if (s.keys.paint_now) begin
      w.x    = s.x;
      w.y    = s.y;
      w.data = model_colour;
      exp_q.push_back(w);
      exp_names.push_back(name);
    end else begin
      for (int i = 0; i < paint_ctrl_pkg::CURSOR_PIXELS; i++) begin
        w.x    = paint_geom_pkg::coord_t'((int'(s.x) + i % 2) % paint_geom_pkg::CANVAS_SIZE);
        w.y    = paint_geom_pkg::coord_t'((int'(s.y) + i / 2) % paint_geom_pkg::CANVAS_SIZE);
        w.data = paint_geom_pkg::CURSOR_PIXEL;
        exp_q.push_back(w);
        exp_names.push_back(name);
      end
    end
  endtask

  task automatic wait_strobe(input string name);
    int n = 0;
    @(negedge clk);
    while (!sample_strobe && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!sample_strobe) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout in %s while waiting for sample_strobe", name);
    end
  endtask

  task automatic wait_writes(input string name, input int count);
    int seen = 0;
    int n = 0;
    while (seen < count && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      if (pix_wr.valid) seen++;
      n++;
    end
    if (seen < count) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout in %s after %0d of %0d pixel writes", name, seen, count);
    end
  endtask

  task automatic drain_expected();
    int n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout while %0d predicted pixel writes were still missing", exp_q.size());
    end
  endtask

  // Every write on the output is matched in order against the model
  always @(negedge clk) begin
    if (checking && pix_wr.valid) begin
      if (exp_q.size() == 0) begin
        unexpected++;
        $display("Pixel write to x=%0d y=%0d data %h was not expected",
                 pix_wr.x, pix_wr.y, pix_wr.data);
      end else begin
        check(exp_names.pop_front(), exp_q.pop_front(), pix_wr);
      end
    end
  end

  initial begin
    stim_t s;
    void'($urandom(32'h89f3_00df));
    rst  <= 1'b1;
    init <= 1'b0;
    in_x <= '0;
    in_y <= '0;
    keys <= '0;
    checking     = 1'b0;
    timed_out    = 1'b0;
    mismatches   = 0;
    unexpected   = 0;
    timeouts     = 0;
    model_colour = '0;
    add_row("paint_default", 1'b0,  5,  9, 3'b010);
    add_row("cursor_mid",    1'b0, 20, 30, 3'b000);
    add_row("cursor_wrap",   1'b0, 63, 63, 3'b000);
    add_row("palette_pick",  1'b0, 42, 23, 3'b101);
    add_row("paint_picked",  1'b0,  1,  2, 3'b010);
    add_row("cursor_edge_x", 1'b0, 63, 10, 3'b000);
    add_row("rand_cursor_a", 1'b1,  0,  0, 3'b000);
    add_row("rand_cursor_b", 1'b1,  0,  0, 3'b000);
    add_row("rand_paint_a",  1'b1,  0,  0, 3'b010);
    add_row("rand_palette",  1'b1,  0,  0, 3'b111);
    add_row("rand_cursor_c", 1'b1,  0,  0, 3'b000);
    add_row("rand_cursor_d", 1'b1,  0,  0, 3'b000);
    add_row("rand_paint_b",  1'b1,  0,  0, 3'b010);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    checking = 1'b1;
    repeat (12) begin
      @(negedge clk);
      check("idle_quiet", 32'd0, {30'd0, pix_wr.valid, sample_strobe});
    end
    for (int i = 0; i < rows.size(); i++) begin
      s = rows[i];
      if (s.rand_pos) begin
        s.x = paint_geom_pkg::coord_t'($urandom % paint_geom_pkg::CANVAS_SIZE);
        s.y = paint_geom_pkg::coord_t'($urandom % paint_geom_pkg::CANVAS_SIZE);
      end
      predict(row_names[i], s);
      @(posedge clk);
      init <= 1'b1;
      in_x <= s.x;
      in_y <= s.y;
      keys <= s.keys;
      wait_strobe(row_names[i]);
      if (timed_out) break;
      // Keys must hold until the last state that reads them has passed
      if (s.keys.pick_palette) begin
        wait_writes(row_names[i], paint_ctrl_pkg::PALETTE_SWATCHES);
        if (timed_out) break;
      end else begin
        repeat (2) @(negedge clk);
      end
    end
    if (!timed_out) drain_expected();
    @(posedge clk);
    checking = 1'b0;
    $display("Errors: %0d mismatches, %0d unexpected writes, %0d timeouts, %0d assertion failures",
             mismatches, unexpected, timeouts,
             i_paint_top.i_controller.i_paint_assertions.fail_count);
    if (mismatches + unexpected + timeouts +
        i_paint_top.i_controller.i_paint_assertions.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: paint.f
design/paint_geom_pkg.sv
design/paint_ctrl_pkg.sv
design/cursor_drawer.sv
design/palette_drawer.sv
design/paint_controller.sv
design/paint_top.sv
test/paint_assertions.sv
test/paint_tb.sv

// File: Bender.yml
package:
  name: paint

sources:
  - files:
      - design/paint_geom_pkg.sv
      - design/paint_ctrl_pkg.sv
      - design/cursor_drawer.sv
      - design/palette_drawer.sv
      - design/paint_controller.sv
      - design/paint_top.sv
  - target: test
    files:
      - test/paint_assertions.sv
      - test/paint_tb.sv
